//--- Makefile
SIM  := obj_dir/Vtb_mpu
SRCS := $(shell cat vlog.f)

.PHONY: all run clean

all: run

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_mpu -f vlog.f -o Vtb_mpu

run: $(SIM)
	./$(SIM) 2>&1 | tee sim.log
	@grep -q "All checks passed" sim.log
	@! grep -q "Checks failed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- hw/mpu_ctrl.sv
/*
  MPU access controller
  Forwards an allowed access to the Wishbone master port with
  the winning region's memory type, or answers a denied one
  with an error. Returns a registered one-cycle response to
  the core in either case
*/
`timescale 1ns/1ps
`default_nettype none

module mpu_ctrl (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         req_valid_i,
  input  logic                         req_we_i,
  input  logic                         allow_i,
  input  logic [mpu_pkg::ADDR_W-1:0]   req_adr_i,
  input  logic [mpu_pkg::DATA_W-1:0]   req_dat_i,
  input  logic [mpu_pkg::DATA_W/8-1:0] req_sel_i,
  input  mpu_pkg::pma_attr_t           attr_i,
  input  logic                         bus_ack_i,
  input  logic [mpu_pkg::DATA_W-1:0]   bus_dat_i,
  output logic                         busy_o,
  output logic                         core_ack_o,
  output logic                         core_err_o,
  output logic                         bus_cyc_o,
  output logic                         bus_stb_o,
  output logic                         bus_we_o,
  output logic [mpu_pkg::DATA_W-1:0]   core_dat_o,
  output logic [mpu_pkg::ADDR_W-1:0]   bus_adr_o,
  output logic [mpu_pkg::DATA_W-1:0]   bus_dat_o,
  output logic [mpu_pkg::DATA_W/8-1:0] bus_sel_o,
  output logic [1:0]                   bus_memtype_o
);

  mpu_pkg::mpu_state_e state_q;
  mpu_pkg::mpu_state_e state_cur;

  // The cycle carrying a fresh request is the check cycle
  always_comb begin
    state_cur = state_q;
    if (state_q == mpu_pkg::MPU_IDLE && req_valid_i) begin
      state_cur = mpu_pkg::MPU_CHECK;
    end
  end

  assign busy_o = (state_cur != mpu_pkg::MPU_IDLE);

  //////////////////////////////
  // State and handshake flags
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q    <= mpu_pkg::MPU_IDLE;
      bus_cyc_o  <= 1'b0;
      core_ack_o <= 1'b0;
      core_err_o <= 1'b0;
    end else begin
      case (state_cur)
        mpu_pkg::MPU_CHECK: begin
          if (allow_i) begin
            state_q   <= mpu_pkg::MPU_BUS;
            bus_cyc_o <= 1'b1;
          end else begin
            state_q    <= mpu_pkg::MPU_ERR;
            core_err_o <= 1'b1;
          end
        end
        mpu_pkg::MPU_BUS: begin
          // Hold the cycle through wait states
          if (bus_ack_i) begin
            state_q    <= mpu_pkg::MPU_RESP;
            bus_cyc_o  <= 1'b0;
            core_ack_o <= 1'b1;
          end
        end
        mpu_pkg::MPU_RESP, mpu_pkg::MPU_ERR: begin
          state_q    <= mpu_pkg::MPU_IDLE;
          core_ack_o <= 1'b0;
          core_err_o <= 1'b0;
        end
        default: state_q <= mpu_pkg::MPU_IDLE;
      endcase
    end
  end

  // Memory type latched once per access, read data once per ack
  always_ff @(posedge clk) begin
    if (state_cur == mpu_pkg::MPU_CHECK) begin
      bus_memtype_o <= {attr_i.cacheable, attr_i.bufferable};
    end
    if (state_cur == mpu_pkg::MPU_BUS && bus_ack_i) begin
      core_dat_o <= bus_dat_i;
    end
  end

  // Captured fields are frozen while busy
  assign bus_stb_o = bus_cyc_o;
  assign bus_we_o  = req_we_i;
  assign bus_adr_o = req_adr_i;
  assign bus_dat_o = req_dat_i;
  assign bus_sel_o = req_sel_i;

  //////////////////////////////
  // Checks
  //////////////////////////////
  a_err_not_on_bus : assert property (@(posedge clk) disable iff (rst_n)
    !(core_err_o && bus_cyc_o))
    else $error("Denied access reached the bus");

  a_memtype_stable : assert property (@(posedge clk) disable iff (rst_n)
    (bus_stb_o && !bus_ack_i) |=> $stable(bus_memtype_o))
    else $error("Memory type changed during a bus wait state");

  a_idle_when_free : assert property (@(posedge clk) disable iff (rst_n)
    !busy_o |-> (state_q == mpu_pkg::MPU_IDLE) && !bus_cyc_o && !core_ack_o && !core_err_o)
    else $error("Controller free while an access is still open");

endmodule

`default_nettype wire

//--- hw/mpu_pkg.sv
/*
  Memory protection unit shared definitions
  Bus widths, the PMA region attribute record, the controller
  state encoding and the fixed region table with its lowest-index
  priority order
*/
`default_nettype none

package mpu_pkg;

  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int NUM_REGIONS = 4;

  // Bounds are word addresses, low inclusive and high exclusive
  typedef struct packed {
    logic [ADDR_W-3:0] word_addr_low;
    logic [ADDR_W-3:0] word_addr_high;
    logic              main;
    logic              executable;
    logic              bufferable;
    logic              cacheable;
  } pma_attr_t;

  typedef enum logic [2:0] {
    MPU_IDLE,
    MPU_CHECK,
    MPU_BUS,
    MPU_RESP,
    MPU_ERR
  } mpu_state_e;

  // Used when no region matches, denies everything
  localparam pma_attr_t PMA_DEFAULT = '{default: '0};

  //////////////////////////////
  // Region table, index 0 has highest priority
  //////////////////////////////
  localparam pma_attr_t PMA_TABLE [NUM_REGIONS] = '{
    // 0x0000_0000 .. 0x0000_4000 code and data RAM
    '{word_addr_low: 30'h0000_0000, word_addr_high: 30'h0000_1000,
      main: 1'b1, executable: 1'b1, bufferable: 1'b1, cacheable: 1'b1},
    // 0x0000_2000 .. 0x0001_0000 data RAM, lower part shadowed by region 0
    '{word_addr_low: 30'h0000_0800, word_addr_high: 30'h0000_4000,
      main: 1'b1, executable: 1'b0, bufferable: 1'b1, cacheable: 1'b0},
    // 0x1000_0000 .. 0x1000_1000 strongly ordered peripherals
    '{word_addr_low: 30'h0400_0000, word_addr_high: 30'h0400_0400,
      main: 1'b0, executable: 1'b0, bufferable: 1'b0, cacheable: 1'b0},
    // 0x2000_0000 .. 0x2000_0100 posted-write peripherals
    '{word_addr_low: 30'h0800_0000, word_addr_high: 30'h0800_0040,
      main: 1'b0, executable: 1'b0, bufferable: 1'b1, cacheable: 1'b0}
  };

endpackage

`default_nettype wire

//--- hw/mpu_req_capture.sv
/*
  Core request capture
  Registers one Wishbone request from the core while the
  controller is idle and flags it with a single-cycle valid.
  The captured fields stay put until the next capture
*/
`timescale 1ns/1ps
`default_nettype none

module mpu_req_capture (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         core_cyc_i,
  input  logic                         core_stb_i,
  input  logic                         core_we_i,
  input  logic                         core_exec_i,
  input  logic [mpu_pkg::ADDR_W-1:0]   core_adr_i,
  input  logic [mpu_pkg::DATA_W-1:0]   core_dat_i,
  input  logic [mpu_pkg::DATA_W/8-1:0] core_sel_i,
  input  logic                         busy_i,
  output logic                         req_valid_o,
  output logic                         req_we_o,
  output logic                         req_exec_o,
  output logic [mpu_pkg::ADDR_W-1:0]   req_adr_o,
  output logic [mpu_pkg::DATA_W-1:0]   req_dat_o,
  output logic [mpu_pkg::DATA_W/8-1:0] req_sel_o
);

  logic take;

  // Only a strobed cycle seen while the controller is free
  assign take = core_cyc_i && core_stb_i && !busy_i;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      req_valid_o <= 1'b0;
    end else begin
      req_valid_o <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      req_adr_o  <= core_adr_i;
      req_dat_o  <= core_dat_i;
      req_sel_o  <= core_sel_i;
      req_we_o   <= core_we_i;
      req_exec_o <= core_exec_i;
    end
  end

  // Controller must raise busy in the cycle the request is presented
  a_single_pulse : assert property (@(posedge clk) disable iff (rst_n)
    req_valid_o |=> !req_valid_o)
    else $error("Request captured twice in a row");

endmodule

`default_nettype wire

//--- hw/mpu_top.sv
/*
  Memory protection unit top level
  Wishbone classic slave towards the core, Wishbone classic
  master towards memory. Checks each access against the fixed
  PMA table and blocks denied ones
*/
`timescale 1ns/1ps
`default_nettype none

module mpu_top (
  input  logic                         clk,
  input  logic                         rst_n,
  // Core side
  input  logic                         core_cyc_i,
  input  logic                         core_stb_i,
  input  logic                         core_we_i,
  input  logic [mpu_pkg::ADDR_W-1:0]   core_adr_i,
  input  logic [mpu_pkg::DATA_W-1:0]   core_dat_i,
  input  logic [mpu_pkg::DATA_W/8-1:0] core_sel_i,
  input  logic                         core_exec_i,
  output logic                         core_ack_o,
  output logic                         core_err_o,
  output logic [mpu_pkg::DATA_W-1:0]   core_dat_o,
  // Bus side
  output logic                         bus_cyc_o,
  output logic                         bus_stb_o,
  output logic                         bus_we_o,
  output logic [mpu_pkg::ADDR_W-1:0]   bus_adr_o,
  output logic [mpu_pkg::DATA_W-1:0]   bus_dat_o,
  output logic [mpu_pkg::DATA_W/8-1:0] bus_sel_o,
  output logic [1:0]                   bus_memtype_o,
  input  logic                         bus_ack_i,
  input  logic [mpu_pkg::DATA_W-1:0]   bus_dat_i
);

  logic                         busy;
  logic                         req_valid;
  logic                         req_we;
  logic                         req_exec;
  logic [mpu_pkg::ADDR_W-1:0]   req_adr;
  logic [mpu_pkg::DATA_W-1:0]   req_dat;
  logic [mpu_pkg::DATA_W/8-1:0] req_sel;
  logic [mpu_pkg::NUM_REGIONS-1:0] region_hit;
  mpu_pkg::pma_attr_t           region_attr [mpu_pkg::NUM_REGIONS];
  logic                         allow;
  mpu_pkg::pma_attr_t           sel_attr;

  mpu_req_capture u_capture (
    .clk         (clk),
    .rst_n       (rst_n),
    .core_cyc_i  (core_cyc_i),
    .core_stb_i  (core_stb_i),
    .core_we_i   (core_we_i),
    .core_exec_i (core_exec_i),
    .core_adr_i  (core_adr_i),
    .core_dat_i  (core_dat_i),
    .core_sel_i  (core_sel_i),
    .busy_i      (busy),
    .req_valid_o (req_valid),
    .req_we_o    (req_we),
    .req_exec_o  (req_exec),
    .req_adr_o   (req_adr),
    .req_dat_o   (req_dat),
    .req_sel_o   (req_sel)
  );

  // One comparator per table entry
  for (genvar g = 0; g < mpu_pkg::NUM_REGIONS; g++) begin : g_region
    pma_region_match #(
      .REGION_IDX (g)
    ) u_match (
      .req_adr_i (req_adr),
      .hit_o     (region_hit[g]),
      .attr_o    (region_attr[g])
    );
  end

  pma_lowest_select u_select (
    .clk        (clk),
    .rst_n      (rst_n),
    .hit_i      (region_hit),
    .attr_i     (region_attr),
    .req_adr_i  (req_adr),
    .req_exec_i (req_exec),
    .allow_o    (allow),
    .attr_o     (sel_attr)
  );

  mpu_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid),
    .req_we_i      (req_we),
    .allow_i       (allow),
    .req_adr_i     (req_adr),
    .req_dat_i     (req_dat),
    .req_sel_i     (req_sel),
    .attr_i        (sel_attr),
    .bus_ack_i     (bus_ack_i),
    .bus_dat_i     (bus_dat_i),
    .busy_o        (busy),
    .core_ack_o    (core_ack_o),
    .core_err_o    (core_err_o),
    .bus_cyc_o     (bus_cyc_o),
    .bus_stb_o     (bus_stb_o),
    .bus_we_o      (bus_we_o),
    .core_dat_o    (core_dat_o),
    .bus_adr_o     (bus_adr_o),
    .bus_dat_o     (bus_dat_o),
    .bus_sel_o     (bus_sel_o),
    .bus_memtype_o (bus_memtype_o)
  );

endmodule

`default_nettype wire

//--- hw/pma_lowest_select.sv
/*
  PMA priority selector
  Picks the lowest-index region that hits and decides whether
  the access may proceed. No hit, or a fetch from a region that
  is not executable, denies it
*/
`timescale 1ns/1ps
`default_nettype none

module pma_lowest_select (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [mpu_pkg::NUM_REGIONS-1:0]  hit_i,
  input  mpu_pkg::pma_attr_t               attr_i [mpu_pkg::NUM_REGIONS],
  input  logic [mpu_pkg::ADDR_W-1:0]       req_adr_i,
  input  logic                             req_exec_i,
  output logic                             allow_o,
  output mpu_pkg::pma_attr_t               attr_o
);

  logic any_hit;

  assign any_hit = |hit_i;

  // Walk downwards so the lowest hitting index is written last
  always_comb begin
    attr_o  = mpu_pkg::PMA_DEFAULT;
    allow_o = 1'b0;
    for (int i = mpu_pkg::NUM_REGIONS - 1; i >= 0; i--) begin
      if (hit_i[i]) begin
        attr_o  = attr_i[i];
        allow_o = !req_exec_i || attr_i[i].executable;
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Selected attributes really belong to a region covering the address
  a_hit_in_bounds : assert property (@(posedge clk) disable iff (rst_n)
    any_hit |-> (({attr_o.word_addr_low, 2'b00} <= req_adr_i) &&
                 (req_adr_i < {attr_o.word_addr_high, 2'b00})))
    else $error("Selected PMA region does not cover the request address");

  a_allow_needs_hit : assert property (@(posedge clk) disable iff (rst_n)
    allow_o |-> any_hit)
    else $error("Access allowed without a region hit");

endmodule

`default_nettype wire

//--- hw/pma_region_match.sv
/*
  PMA region comparator
  Tests one address against a single entry of the region table
  and hands that entry's attributes on to the priority selector
*/
`timescale 1ns/1ps
`default_nettype none

module pma_region_match #(
  parameter int REGION_IDX = 0
) (
  input  logic [mpu_pkg::ADDR_W-1:0] req_adr_i,
  output logic                       hit_o,
  output mpu_pkg::pma_attr_t         attr_o
);

  localparam mpu_pkg::pma_attr_t REGION_ATTR = mpu_pkg::PMA_TABLE[REGION_IDX];

  // Byte bounds from the word bounds
  localparam logic [mpu_pkg::ADDR_W-1:0] BASE_ADR = {REGION_ATTR.word_addr_low, 2'b00};
  localparam logic [mpu_pkg::ADDR_W-1:0] TOP_ADR  = {REGION_ATTR.word_addr_high, 2'b00};

  assign hit_o  = (req_adr_i >= BASE_ADR) && (req_adr_i < TOP_ADR);
  assign attr_o = REGION_ATTR;

  // Table sanity, evaluated once per region
  initial begin
    if (!REGION_ATTR.main && REGION_ATTR.cacheable) begin
      $error("PMA region %0d is I/O but marked cacheable", REGION_IDX);
    end
    if (BASE_ADR >= TOP_ADR) begin
      $error("PMA region %0d has an empty address range", REGION_IDX);
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_mpu.sv
/*
  Memory protection unit testbench
  Applies a table of core accesses through the Wishbone slave port,
  answers bus cycles from a memory model with random wait states
  and checks the error flag, memory type and read data per access
*/
`timescale 1ns/1ps
`default_nettype none

module tb_mpu;

  localparam int          CLK_PERIOD   = 40;
  localparam int          RESET_CYCLES = 3;
  localparam int          NUM_TESTS    = 16;
  localparam int          RESP_LIMIT   = 12;
  localparam int          WATCHDOG_NS  = (NUM_TESTS * 12 + RESET_CYCLES) * CLK_PERIOD;
  localparam logic [31:0] RD_PATTERN   = 32'h5a5a_5a5a;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        core_cyc_i;
  logic        core_stb_i;
  logic        core_we_i;
  logic [31:0] core_adr_i;
  logic [31:0] core_dat_i;
  logic [3:0]  core_sel_i;
  logic        core_exec_i;
  logic        core_ack_o;
  logic        core_err_o;
  logic [31:0] core_dat_o;
  logic        bus_cyc_o;
  logic        bus_stb_o;
  logic        bus_we_o;
  logic [31:0] bus_adr_o;
  logic [31:0] bus_dat_o;
  logic [3:0]  bus_sel_o;
  logic [1:0]  bus_memtype_o;
  logic        bus_ack_i;
  logic [31:0] bus_dat_i;

  // Stimulus table with expected results
  string       t_name [NUM_TESTS];
  logic [31:0] t_adr  [NUM_TESTS];
  logic        t_we   [NUM_TESTS];
  logic        t_exec [NUM_TESTS];
  logic [31:0] t_wdat [NUM_TESTS];
  logic        t_err  [NUM_TESTS];
  logic [1:0]  t_mt   [NUM_TESTS];
  logic [31:0] t_rdat [NUM_TESTS];
  int          n_entries = 0;

  // Access currently on the core port as seen by the memory model
  int          cur_idx = 0;
  int          errors = 0;
  int          bus_cycles = 0;
  int          resp_count = 0;
  integer      seed = 32'he304;
  int          wait_left = 0;
  logic        active = 1'b0;
  logic [1:0]  seen_mt = 2'b00;

  mpu_top UUT (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic add_entry(input string name, input logic [31:0] adr, input logic we,
                           input logic exec, input logic [31:0] wdat,
                           input logic exp_err, input logic [1:0] exp_mt);
    t_name[n_entries] = name;
    t_adr[n_entries]  = adr;
    t_we[n_entries]   = we;
    t_exec[n_entries] = exec;
    t_wdat[n_entries] = wdat;
    t_err[n_entries]  = exp_err;
    t_mt[n_entries]   = exp_mt;
    // Memory returns address XOR pattern on every acked cycle
    t_rdat[n_entries] = adr ^ RD_PATTERN;
    n_entries++;
  endtask

  //////////////////////////////
  // Bus memory model
  //////////////////////////////
  always @(negedge clk) begin
    if (rst_n) begin
      bus_ack_i = 1'b0;
      bus_dat_i = 32'h0;
      active    = 1'b0;
    end else if (bus_ack_i) begin
      bus_ack_i = 1'b0;
      active    = 1'b0;
    end else if (bus_cyc_o && bus_stb_o) begin
      if (!active) begin
        active    = 1'b1;
        wait_left = $unsigned($random(seed)) % 4;
        seen_mt   = bus_memtype_o;
        bus_cycles++;
      end
      // Checked on every sampled cycle including wait states
      if (bus_adr_o !== t_adr[cur_idx]) begin
        $display("ERR %s: bus_adr expected %h got %h", t_name[cur_idx], t_adr[cur_idx],
                 bus_adr_o);
        errors++;
      end
      if (bus_memtype_o !== t_mt[cur_idx]) begin
        $display("ERR %s: bus_memtype expected %b got %b", t_name[cur_idx], t_mt[cur_idx],
                 bus_memtype_o);
        errors++;
      end
      if (bus_we_o !== t_we[cur_idx]) begin
        $display("ERR %s: bus_we expected %b got %b", t_name[cur_idx], t_we[cur_idx], bus_we_o);
        errors++;
      end
      if (bus_sel_o !== core_sel_i) begin
        $display("ERR %s: bus_sel expected %h got %h", t_name[cur_idx], core_sel_i,
                 bus_sel_o);
        errors++;
      end
      if (t_we[cur_idx] && bus_dat_o !== t_wdat[cur_idx]) begin
        $display("ERR %s: bus_dat expected %h got %h", t_name[cur_idx], t_wdat[cur_idx],
                 bus_dat_o);
        errors++;
      end
      if (wait_left == 0) begin
        bus_ack_i = 1'b1;
        bus_dat_i = bus_adr_o ^ RD_PATTERN;
      end else begin
        wait_left--;
      end
    end
  end

  // Count core responses to check one per access
  always @(negedge clk) begin
    if (core_ack_o || core_err_o) begin
      resp_count++;
    end
  end

  task automatic run_entry(input int idx);
    int          waited;
    int          cycles_before;
    logic        got_ack;
    logic        got_err;
    logic [31:0] got_dat;
    cur_idx       = idx;
    cycles_before = bus_cycles;
    core_adr_i    = t_adr[idx];
    core_we_i     = t_we[idx];
    core_exec_i   = t_exec[idx];
    core_dat_i    = t_wdat[idx];
    core_sel_i    = 4'hf >> (idx % 4);
    core_cyc_i    = 1'b1;
    core_stb_i    = 1'b1;
    waited  = 0;
    got_ack = 1'b0;
    got_err = 1'b0;
    got_dat = 32'h0;
    while (!got_ack && !got_err && waited < RESP_LIMIT) begin
      @(negedge clk);
      got_ack = core_ack_o;
      got_err = core_err_o;
      got_dat = core_dat_o;
      waited++;
    end
    if (!got_ack && !got_err) begin
      $display("Access %s got no response within %0d cycles", t_name[idx], RESP_LIMIT);
      errors++;
    end
    // Drop the strobe in the cycle after the response
    @(negedge clk);
    core_cyc_i = 1'b0;
    core_stb_i = 1'b0;
    if (core_ack_o || core_err_o) begin
      $display("Access %s got a response lasting more than one cycle", t_name[idx]);
      errors++;
    end
    if (resp_count != idx + 1) begin
      $display("Access %s: %0d responses seen after %0d accesses", t_name[idx], resp_count,
               idx + 1);
      errors++;
    end
    if (got_err !== t_err[idx]) begin
      $display("ERR %s: core_err expected %b got %b", t_name[idx], t_err[idx], got_err);
      errors++;
    end
    if (bus_cycles - cycles_before != (t_err[idx] ? 0 : 1)) begin
      $display("ERR %s: bus cycles expected %0d got %0d", t_name[idx], t_err[idx] ? 0 : 1,
               bus_cycles - cycles_before);
      errors++;
    end
    if (got_ack && !t_err[idx]) begin
      if (seen_mt !== t_mt[idx]) begin
        $display("ERR %s: memtype expected %b got %b", t_name[idx], t_mt[idx], seen_mt);
        errors++;
      end
      if (got_dat !== t_rdat[idx]) begin
        $display("ERR %s: core_dat expected %h got %h", t_name[idx], t_rdat[idx], got_dat);
        errors++;
      end
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    rst_n       = 1'b1;
    core_cyc_i  = 1'b0;
    core_stb_i  = 1'b0;
    core_we_i   = 1'b0;
    core_exec_i = 1'b0;
    core_adr_i  = 32'h0;
    core_dat_i  = 32'h0;
    core_sel_i  = 4'h0;
    bus_ack_i   = 1'b0;
    bus_dat_i   = 32'h0;

    // name, address, we, exec, write data, error, memtype
    add_entry("rd_r0",        32'h0000_0100, 1'b0, 1'b0, 32'h0,         1'b0, 2'b11);
    add_entry("wr_r0",        32'h0000_0204, 1'b1, 1'b0, 32'hdead_beef, 1'b0, 2'b11);
    add_entry("rd_overlap",   32'h0000_3000, 1'b0, 1'b0, 32'h0,         1'b0, 2'b11);
    add_entry("wr_r1",        32'h0000_8000, 1'b1, 1'b0, 32'h1234_5678, 1'b0, 2'b01);
    add_entry("rd_r2_io",     32'h1000_0010, 1'b0, 1'b0, 32'h0,         1'b0, 2'b00);
    add_entry("wr_r3_io",     32'h2000_0020, 1'b1, 1'b0, 32'hcafe_f00d, 1'b0, 2'b01);
    add_entry("rd_unmapped",  32'h3000_0000, 1'b0, 1'b0, 32'h0,         1'b1, 2'b00);
    add_entry("fetch_r0",     32'h0000_0040, 1'b0, 1'b1, 32'h0,         1'b0, 2'b11);
    add_entry("fetch_r1",     32'h0000_8000, 1'b0, 1'b1, 32'h0,         1'b1, 2'b00);
    add_entry("data_r1",      32'h0000_8000, 1'b0, 1'b0, 32'h0,         1'b0, 2'b01);
    add_entry("fetch_r2",     32'h1000_0010, 1'b0, 1'b1, 32'h0,         1'b1, 2'b00);
    add_entry("data_r2",      32'h1000_0010, 1'b0, 1'b0, 32'h0,         1'b0, 2'b00);
    add_entry("rd_r1_top",    32'h0000_fffc, 1'b0, 1'b0, 32'h0,         1'b0, 2'b01);
    add_entry("rd_past_r1",   32'h0001_0000, 1'b0, 1'b0, 32'h0,         1'b1, 2'b00);
    add_entry("rd_past_r3",   32'h2000_0100, 1'b0, 1'b0, 32'h0,         1'b1, 2'b00);
    add_entry("rd_r0_top",    32'h0000_3ffc, 1'b0, 1'b0, 32'h0,         1'b0, 2'b11);

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b0;
    @(negedge clk);
    if (core_ack_o || core_err_o || bus_cyc_o || bus_stb_o) begin
      $display("Handshake outputs are not low after reset");
      errors++;
    end

    for (int i = 0; i < NUM_TESTS; i++) begin
      @(negedge clk);
      run_entry(i);
    end

    $display("Ran %0d accesses, %0d bus cycles, %0d errors", NUM_TESTS, bus_cycles, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with accesses still pending", WATCHDOG_NS);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
hw/mpu_pkg.sv
hw/pma_region_match.sv
hw/pma_lowest_select.sv
hw/mpu_req_capture.sv
hw/mpu_ctrl.sv
hw/mpu_top.sv
tb/tb_mpu.sv
